// ==== source/sd_pkg.sv ====
`default_nettype none

package sd_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] sector_t;
    typedef logic [5:0]  cmd_index_t;

    // SD command indices used in SPI mode
    localparam cmd_index_t CMD_GO_IDLE       = 6'd0;
    localparam cmd_index_t CMD_SEND_IF_COND  = 6'd8;
    localparam cmd_index_t CMD_APP           = 6'd55;
    localparam cmd_index_t ACMD_SEND_OP_COND = 6'd41;
    localparam cmd_index_t CMD_SET_BLOCKLEN  = 6'd16;
    localparam cmd_index_t CMD_READ_SINGLE   = 6'd17;

    localparam byte_t R1_IDLE    = 8'h01;  // Card still in idle state
    localparam byte_t R1_READY   = 8'h00;  // No error bits
    localparam byte_t DATA_TOKEN = 8'hFE;  // Start of data block
    localparam byte_t FILL_BYTE  = 8'hFF;  // Idle line, no response yet

    localparam int BLOCK_BYTES   = 512;
    localparam int CRC_BYTES     = 2;
    localparam int POWERUP_BYTES = 10;     // 80 SCK periods

    typedef enum logic [1:0] {
        TXN_POWERUP,                       // FFh bytes with chip select high
        TXN_CMD,                           // Command frame plus response
        TXN_CMD_DATA                       // Command, response and one data block
    } txn_kind_e;

    typedef struct packed {
        txn_kind_e  kind;
        cmd_index_t index;
        sector_t    arg;
        byte_t      crc;                   // Whole last frame byte with end bit
        logic [2:0] extra_bytes;           // Response bytes after R1 to drop
    } txn_req_t;

    typedef struct packed {
        byte_t r1;
        logic  timed_out;
    } txn_rsp_t;

endpackage

`default_nettype wire

// ==== source/sd_spi_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module sd_spi_engine #(
    parameter int INIT_HALF_PERIOD = 125,
    parameter int FAST_HALF_PERIOD = 4
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          fast_clk,
    input  logic          xfer_start,
    input  sd_pkg::byte_t tx_byte,
    input  logic          miso,
    output logic          xfer_done,
    output sd_pkg::byte_t rx_byte,
    output logic          sck,
    output logic          mosi
);

    logic [15:0]   div_cnt;
    logic [15:0]   half_last;
    logic [3:0]    edge_cnt;        // 16 SCK edges per byte
    logic          active;
    logic          tick;
    sd_pkg::byte_t shreg;           // TX bits out the top, RX bits in the bottom

    assign half_last = fast_clk ? 16'(FAST_HALF_PERIOD - 1) : 16'(INIT_HALF_PERIOD - 1);
    assign tick      = active && (div_cnt == half_last);
    assign rx_byte   = shreg;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active    <= 1'b0;
            div_cnt   <= '0;
            edge_cnt  <= '0;
            sck       <= 1'b0;
            mosi      <= 1'b1;
            xfer_done <= 1'b0;
        end else begin
            xfer_done <= 1'b0;
            if (xfer_start && !active) begin
                active   <= 1'b1;
                div_cnt  <= '0;
                edge_cnt <= '0;
                mosi     <= tx_byte[7];          // MSB ready before first rise
            end else if (tick) begin
                div_cnt  <= '0;
                sck      <= ~sck;
                edge_cnt <= edge_cnt + 4'd1;
                if (sck) begin
                    // Falling edge shifts out the next bit, idles high after the last
                    mosi <= (edge_cnt == 4'd15) ? 1'b1 : shreg[7];
                end
                if (edge_cnt == 4'd15) begin
                    active    <= 1'b0;
                    xfer_done <= 1'b1;
                end
            end else if (active) begin
                div_cnt <= div_cnt + 16'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (xfer_start && !active) begin
            shreg <= tx_byte;
        end else if (tick && !sck) begin
            shreg <= {shreg[6:0], miso};         // Sample on rising edge
        end
    end

endmodule

`default_nettype wire

// ==== source/sd_transaction.sv ====
`timescale 1ns/1ns
`default_nettype none

module sd_transaction #(
    parameter int RESP_TIMEOUT_BYTES  = 16,
    parameter int TOKEN_TIMEOUT_BYTES = 200
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             txn_start,
    input  sd_pkg::txn_req_t txn_req,
    input  logic             xfer_done,
    input  sd_pkg::byte_t    rx_byte,
    output logic             txn_done,
    output sd_pkg::txn_rsp_t txn_rsp,
    output logic             xfer_start,
    output sd_pkg::byte_t    tx_byte,
    output logic             cs_n,
    output sd_pkg::byte_t    data_out,
    output logic             data_valid
);

    typedef enum logic [3:0] {
        S_IDLE, S_PWR, S_CMD, S_RESP, S_EXTRA, S_TOKEN, S_DATA, S_CRC, S_TAIL
    } state_e;

    state_e           state;
    state_e           state_nx;
    sd_pkg::txn_req_t req_q;
    sd_pkg::txn_req_t cur_req;
    logic [9:0]       cnt;          // Bytes done in the current state
    logic [2:0]       frame_sel;
    logic [47:0]      frame;
    sd_pkg::byte_t    r1_now;
    logic             got_r1;
    logic             got_tok;
    logic             resp_to;
    logic             tok_to;
    logic             want_data;
    logic             launch;

    assign launch    = txn_start && (state == S_IDLE);
    assign got_r1    = rx_byte != sd_pkg::FILL_BYTE;
    assign got_tok   = rx_byte == sd_pkg::DATA_TOKEN;
    assign resp_to   = cnt == 10'(RESP_TIMEOUT_BYTES - 1);
    assign tok_to    = cnt == 10'(TOKEN_TIMEOUT_BYTES - 1);
    assign r1_now    = (state == S_RESP) ? rx_byte : txn_rsp.r1;
    assign want_data = (req_q.kind == sd_pkg::TXN_CMD_DATA) && (r1_now == sd_pkg::R1_READY);

    // First frame byte comes straight from the request
    assign cur_req   = (state == S_IDLE) ? txn_req : req_q;
    assign frame     = {2'b01, cur_req.index, cur_req.arg, cur_req.crc};
    assign frame_sel = (state == S_IDLE) ? 3'd0 : cnt[2:0] + 3'd1;

    always_comb begin
        state_nx = state;
        case (state)
            S_IDLE: begin
                if (txn_start) begin
                    state_nx = (txn_req.kind == sd_pkg::TXN_POWERUP) ? S_PWR : S_CMD;
                end
            end
            S_PWR: begin
                if (xfer_done && cnt == 10'(sd_pkg::POWERUP_BYTES - 1)) state_nx = S_TAIL;
            end
            S_CMD: begin
                if (xfer_done && cnt == 10'd5) state_nx = S_RESP;
            end
            S_RESP: begin
                if (xfer_done) begin
                    if (got_r1) begin
                        if (req_q.extra_bytes != 3'd0) begin
                            state_nx = S_EXTRA;
                        end else begin
                            state_nx = want_data ? S_TOKEN : S_TAIL;
                        end
                    end else if (resp_to) begin
                        state_nx = S_TAIL;
                    end
                end
            end
            S_EXTRA: begin
                if (xfer_done && cnt == 10'(req_q.extra_bytes) - 10'd1) begin
                    state_nx = want_data ? S_TOKEN : S_TAIL;
                end
            end
            S_TOKEN: begin
                if (xfer_done) begin
                    if (got_tok) begin
                        state_nx = S_DATA;
                    end else if (tok_to) begin
                        state_nx = S_TAIL;
                    end
                end
            end
            S_DATA: begin
                if (xfer_done && cnt == 10'(sd_pkg::BLOCK_BYTES - 1)) state_nx = S_CRC;
            end
            S_CRC: begin
                if (xfer_done && cnt == 10'(sd_pkg::CRC_BYTES - 1)) state_nx = S_TAIL;
            end
            S_TAIL: begin
                if (xfer_done) state_nx = S_IDLE;      // Extra fill byte with CS high
            end
            default: state_nx = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            cnt        <= '0;
            xfer_start <= 1'b0;
            cs_n       <= 1'b1;
            data_valid <= 1'b0;
            txn_done   <= 1'b0;
            txn_rsp    <= '{r1: sd_pkg::FILL_BYTE, timed_out: 1'b0};
        end else begin
            state <= state_nx;
            if (state_nx != state) begin
                cnt <= '0;
            end else if (xfer_done) begin
                cnt <= cnt + 10'd1;
            end
            xfer_start <= launch || (xfer_done && state_nx != S_IDLE);
            cs_n       <= (state_nx == S_IDLE) || (state_nx == S_PWR) || (state_nx == S_TAIL);
            data_valid <= (state == S_DATA) && xfer_done;
            txn_done   <= (state == S_TAIL) && xfer_done;
            if (launch) begin
                txn_rsp <= '{r1: sd_pkg::FILL_BYTE, timed_out: 1'b0};
            end else if (xfer_done) begin
                if (state == S_RESP && got_r1) txn_rsp.r1 <= rx_byte;
                if ((state == S_RESP && !got_r1 && resp_to) ||
                    (state == S_TOKEN && !got_tok && tok_to)) begin
                    txn_rsp.timed_out <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) req_q <= txn_req;
        if (launch || xfer_done) begin
            tx_byte <= (state_nx == S_CMD) ? frame[47 - 8 * frame_sel -: 8] : sd_pkg::FILL_BYTE;
        end
        if (state == S_DATA && xfer_done) data_out <= rx_byte;
    end

endmodule

`default_nettype wire

// ==== source/sd_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module sd_sequencer #(
    parameter int INIT_RETRIES = 1000
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start_read,
    input  sd_pkg::sector_t  sector_addr,
    input  sd_pkg::byte_t    block_count,
    input  logic             txn_done,
    input  sd_pkg::txn_rsp_t txn_rsp,
    output logic             txn_start,
    output sd_pkg::txn_req_t txn_req,
    output logic             fast_clk,
    output logic             busy,
    output logic             error
);

    localparam int RETRY_W = $clog2(INIT_RETRIES + 1);

    typedef enum logic [3:0] {
        S_PWR, S_CMD0, S_CMD8, S_CMD55, S_ACMD41, S_CMD16, S_IDLE, S_READ, S_ERR
    } state_e;

    state_e             state;
    state_e             state_nx;
    logic               pending;        // Transaction in flight
    logic [RETRY_W-1:0] retries;
    sd_pkg::sector_t    sector;
    sd_pkg::byte_t      blocks_left;
    logic               r1_idle;
    logic               r1_ready;

    assign txn_start = !pending && (state != S_IDLE) && (state != S_ERR);
    assign r1_idle   = txn_rsp.r1 == sd_pkg::R1_IDLE;
    assign r1_ready  = txn_rsp.r1 == sd_pkg::R1_READY;

    always_comb begin
        txn_req      = '0;
        txn_req.kind = sd_pkg::TXN_CMD;
        txn_req.crc  = sd_pkg::FILL_BYTE;   // CRC unchecked after CMD8
        case (state)
            S_PWR:    txn_req.kind = sd_pkg::TXN_POWERUP;
            S_CMD0: begin
                txn_req.index = sd_pkg::CMD_GO_IDLE;
                txn_req.crc   = 8'h95;
            end
            S_CMD8: begin
                txn_req.index       = sd_pkg::CMD_SEND_IF_COND;
                txn_req.arg         = 32'h0000_01AA;       // 2.7-3.6 V, check pattern
                txn_req.crc         = 8'h87;
                txn_req.extra_bytes = 3'd4;                // R7 tail
            end
            S_CMD55:  txn_req.index = sd_pkg::CMD_APP;
            S_ACMD41: begin
                txn_req.index = sd_pkg::ACMD_SEND_OP_COND;
                txn_req.arg   = 32'h4000_0000;             // HCS set
            end
            S_CMD16: begin
                txn_req.index = sd_pkg::CMD_SET_BLOCKLEN;
                txn_req.arg   = 32'(sd_pkg::BLOCK_BYTES);
            end
            S_READ: begin
                txn_req.kind  = sd_pkg::TXN_CMD_DATA;
                txn_req.index = sd_pkg::CMD_READ_SINGLE;
                txn_req.arg   = sector;
            end
            default: ;
        endcase
    end

    always_comb begin
        state_nx = state;
        if (state == S_IDLE) begin
            if (start_read && block_count != 8'd0) state_nx = S_READ;
        end else if (txn_done && state != S_ERR) begin
            state_nx = S_ERR;                        // Unless the answer fits below
            if (!txn_rsp.timed_out) begin
                case (state)
                    S_PWR:   state_nx = S_CMD0;
                    S_CMD0:  if (r1_idle) state_nx = S_CMD8;
                    S_CMD8:  if (r1_idle) state_nx = S_CMD55;
                    S_CMD55: if (r1_idle) state_nx = S_ACMD41;
                    S_ACMD41: begin
                        if (r1_ready) begin
                            state_nx = S_CMD16;
                        end else if (r1_idle && retries != RETRY_W'(INIT_RETRIES - 1)) begin
                            state_nx = S_CMD55;
                        end
                    end
                    S_CMD16: if (r1_ready) state_nx = S_IDLE;
                    S_READ: begin
                        if (r1_ready) state_nx = (blocks_left == 8'd1) ? S_IDLE : S_READ;
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= S_PWR;
            pending     <= 1'b0;
            retries     <= '0;
            fast_clk    <= 1'b0;
            busy        <= 1'b1;
            error       <= 1'b0;
            sector      <= '0;
            blocks_left <= '0;
        end else begin
            state <= state_nx;
            busy  <= (state_nx != S_IDLE) && (state_nx != S_ERR);
            if (state_nx == S_ERR) error <= 1'b1;          // Sticky until reset
            if (txn_start) begin
                pending <= 1'b1;
            end else if (txn_done) begin
                pending <= 1'b0;
            end
            if (state == S_ACMD41 && state_nx == S_CMD55) retries <= retries + 1'b1;
            if (state == S_CMD16 && state_nx == S_IDLE) fast_clk <= 1'b1;
            if (state == S_IDLE && state_nx == S_READ) begin
                sector      <= sector_addr;
                blocks_left <= block_count;
            end else if (state == S_READ && txn_done && state_nx == S_READ) begin
                sector      <= sector + 32'd1;
                blocks_left <= blocks_left - 8'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/sd_reader_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module sd_reader_top #(
    parameter int INIT_HALF_PERIOD    = 125,
    parameter int FAST_HALF_PERIOD    = 4,
    parameter int RESP_TIMEOUT_BYTES  = 16,
    parameter int TOKEN_TIMEOUT_BYTES = 200,
    parameter int INIT_RETRIES        = 1000
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            miso,
    input  logic            start_read,
    input  sd_pkg::sector_t sector_addr,
    input  sd_pkg::byte_t   block_count,
    output logic            cs_n,
    output logic            sck,
    output logic            mosi,
    output sd_pkg::byte_t   data_out,
    output logic            data_valid,
    output logic            busy,
    output logic            error
);

    logic             txn_start;
    logic             txn_done;
    sd_pkg::txn_req_t txn_req;
    sd_pkg::txn_rsp_t txn_rsp;
    logic             fast_clk;
    logic             xfer_start;
    logic             xfer_done;
    sd_pkg::byte_t    tx_byte;
    sd_pkg::byte_t    rx_byte;

    sd_sequencer #(
        .INIT_RETRIES (INIT_RETRIES)
    ) u_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_read  (start_read),
        .sector_addr (sector_addr),
        .block_count (block_count),
        .txn_done    (txn_done),
        .txn_rsp     (txn_rsp),
        .txn_start   (txn_start),
        .txn_req     (txn_req),
        .fast_clk    (fast_clk),
        .busy        (busy),
        .error       (error)
    );

    sd_transaction #(
        .RESP_TIMEOUT_BYTES  (RESP_TIMEOUT_BYTES),
        .TOKEN_TIMEOUT_BYTES (TOKEN_TIMEOUT_BYTES)
    ) u_transaction (
        .clk        (clk),
        .rst_n      (rst_n),
        .txn_start  (txn_start),
        .txn_req    (txn_req),
        .xfer_done  (xfer_done),
        .rx_byte    (rx_byte),
        .txn_done   (txn_done),
        .txn_rsp    (txn_rsp),
        .xfer_start (xfer_start),
        .tx_byte    (tx_byte),
        .cs_n       (cs_n),
        .data_out   (data_out),
        .data_valid (data_valid)
    );

    sd_spi_engine #(
        .INIT_HALF_PERIOD (INIT_HALF_PERIOD),
        .FAST_HALF_PERIOD (FAST_HALF_PERIOD)
    ) u_engine (
        .clk        (clk),
        .rst_n      (rst_n),
        .fast_clk   (fast_clk),
        .xfer_start (xfer_start),
        .tx_byte    (tx_byte),
        .miso       (miso),
        .xfer_done  (xfer_done),
        .rx_byte    (rx_byte),
        .sck        (sck),
        .mosi       (mosi)
    );

endmodule

`default_nettype wire

// ==== tb/tb_sd_card.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_sd_card (
    input  logic            cs_n,
    input  logic            sck,
    input  logic            mosi,
    input  logic            bad_en,
    input  sd_pkg::sector_t bad_sector,
    output logic            miso
);

    sd_pkg::byte_t   tx_q[$];                  // Bytes waiting to go out on MISO
    sd_pkg::byte_t   frame[0:5];
    sd_pkg::byte_t   rx_sh          = 8'hFF;
    sd_pkg::byte_t   cur_tx         = 8'hFF;
    logic [2:0]      bit_cnt        = 3'd0;
    int              frame_len      = 0;
    logic            app_cmd        = 1'b0;    // Last command was CMD55
    int              acmd41_retries = 0;       // ACMD41 answers that were still idle
    sd_pkg::sector_t blocklen_arg   = '0;
    int              cmd17_count    = 0;
    sd_pkg::sector_t cmd17_args[0:63];

    initial miso = 1'b1;

    task automatic send_block(input sd_pkg::sector_t sector);
        repeat (5) tx_q.push_back(sd_pkg::FILL_BYTE);
        tx_q.push_back(sd_pkg::DATA_TOKEN);
        for (int i = 0; i < sd_pkg::BLOCK_BYTES; i++) begin
            tx_q.push_back(sd_pkg::byte_t'(sector + 32'(i)) ^ 8'h5A);
        end
        tx_q.push_back(8'hC3);                 // CRC bytes, never checked
        tx_q.push_back(8'h3C);
    endtask

    task automatic answer(input sd_pkg::cmd_index_t index, input sd_pkg::sector_t arg);
        tx_q.push_back(sd_pkg::FILL_BYTE);     // Two bytes of think time
        tx_q.push_back(sd_pkg::FILL_BYTE);
        case (index)
            sd_pkg::CMD_GO_IDLE: tx_q.push_back(sd_pkg::R1_IDLE);
            sd_pkg::CMD_SEND_IF_COND: begin
                tx_q.push_back(sd_pkg::R1_IDLE);
                tx_q.push_back(8'h00);         // R7 tail, echoes voltage and pattern
                tx_q.push_back(8'h00);
                tx_q.push_back(8'h01);
                tx_q.push_back(8'hAA);
            end
            sd_pkg::CMD_APP: tx_q.push_back(sd_pkg::R1_IDLE);
            sd_pkg::ACMD_SEND_OP_COND: begin
                if (!app_cmd) begin
                    tx_q.push_back(8'h04);     // Illegal without CMD55
                end else if (acmd41_retries < 3) begin
                    tx_q.push_back(sd_pkg::R1_IDLE);
                    acmd41_retries++;
                end else begin
                    tx_q.push_back(sd_pkg::R1_READY);
                end
            end
            sd_pkg::CMD_SET_BLOCKLEN: begin
                tx_q.push_back(sd_pkg::R1_READY);
                blocklen_arg = arg;
            end
            sd_pkg::CMD_READ_SINGLE: begin
                tx_q.push_back(sd_pkg::R1_READY);
                if (cmd17_count < 64) cmd17_args[cmd17_count] = arg;
                cmd17_count++;
                // A bad sector never produces its token
                if (!(bad_en && arg == bad_sector)) send_block(arg);
            end
            default: tx_q.push_back(8'h04);
        endcase
        app_cmd = (index == sd_pkg::CMD_APP);
    endtask

    task automatic take_byte(input sd_pkg::byte_t b);
        if (frame_len == 0 && b[7:6] == 2'b01) begin
            frame[0]  = b;
            frame_len = 1;
        end else if (frame_len != 0) begin
            frame[frame_len] = b;
            frame_len++;
            if (frame_len == 6) begin
                frame_len = 0;
                answer(frame[0][5:0], {frame[1], frame[2], frame[3], frame[4]});
            end
        end
    endtask

    // Sample MOSI on rising SCK, chip select high resets the byte framing
    always @(posedge sck or posedge cs_n) begin
        if (cs_n) begin
            bit_cnt   = 3'd0;
            frame_len = 0;
            cur_tx    = sd_pkg::FILL_BYTE;
            tx_q.delete();
        end else begin
            rx_sh = {rx_sh[6:0], mosi};
            if (bit_cnt == 3'd7) begin
                take_byte(rx_sh);
                if (tx_q.size() != 0) begin
                    cur_tx = tx_q.pop_front();
                end else begin
                    cur_tx = sd_pkg::FILL_BYTE;
                end
            end
            bit_cnt = bit_cnt + 3'd1;          // Wraps to zero at the byte boundary
        end
    end

    always @(negedge sck or posedge cs_n) begin
        if (cs_n) begin
            miso <= 1'b1;
        end else begin
            miso <= cur_tx[3'd7 - bit_cnt];    // MSB first, changes on falling edge
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_sd_reader_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_sd_reader_assert (
    input logic clk,
    input logic rst_n,
    input logic data_valid,
    input logic busy,
    input logic error,
    input logic cs_n
);

    int fail_count = 0;

    a_valid_in_read: assert property (@(posedge clk) disable iff (!rst_n)
        data_valid |-> (busy && !error))
        else begin
            fail_count++;
            $error("data_valid outside an active read");
        end

    a_error_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        error |=> error)
        else begin
            fail_count++;
            $error("error dropped before reset");
        end

    a_cs_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !busy |-> cs_n)
        else begin
            fail_count++;
            $error("chip select low while not busy");
        end

endmodule

bind sd_reader_top tb_sd_reader_assert u_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .data_valid (data_valid),
    .busy       (busy),
    .error      (error),
    .cs_n       (cs_n)
);

`default_nettype wire

// ==== tb/tb_sd_reader.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_sd_reader;

    localparam int INIT_HALF    = 3;
    localparam int FAST_HALF    = 1;
    localparam int CLK_NS       = 4;
    localparam int SLOW_BYTE_NS = (16 * INIT_HALF + 4) * CLK_NS;
    localparam int FAST_BYTE_NS = (16 * FAST_HALF + 4) * CLK_NS;
    localparam int INIT_BYTES   = 200;     // Power-up and init commands, rounded up

    logic            clk = 1'b0;
    logic            rst_n;
    logic            start_read;
    sd_pkg::sector_t sector_addr;
    sd_pkg::byte_t   block_count;
    logic            miso;
    logic            cs_n;
    logic            sck;
    logic            mosi;
    sd_pkg::byte_t   data_out;
    logic            data_valid;
    logic            busy;
    logic            error;
    logic            bad_en;
    sd_pkg::sector_t bad_sector;
    sd_pkg::byte_t   rx_q[$];              // Bytes seen on data_out
    int              watchdog_ns = 0;

    sd_reader_top #(
        .INIT_HALF_PERIOD (INIT_HALF),
        .FAST_HALF_PERIOD (FAST_HALF)
    ) u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .miso        (miso),
        .start_read  (start_read),
        .sector_addr (sector_addr),
        .block_count (block_count),
        .cs_n        (cs_n),
        .sck         (sck),
        .mosi        (mosi),
        .data_out    (data_out),
        .data_valid  (data_valid),
        .busy        (busy),
        .error       (error)
    );

    tb_sd_card u_card (
        .cs_n       (cs_n),
        .sck        (sck),
        .mosi       (mosi),
        .bad_en     (bad_en),
        .bad_sector (bad_sector),
        .miso       (miso)
    );

    always #2 clk = ~clk;

    always @(negedge clk) begin
        if (data_valid) rx_q.push_back(data_out);
    end

    initial begin
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("Timeout: the reader did not finish within %0d ns", watchdog_ns);
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

    function automatic sd_pkg::byte_t expected_byte(input sd_pkg::sector_t s, input int i);
        return sd_pkg::byte_t'(s + 32'(i)) ^ 8'h5A;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "check %s failed", name);
        end
    endtask

    task automatic strobe_read(input sd_pkg::sector_t sector, input sd_pkg::byte_t count);
        @(posedge clk);
        #1;
        sector_addr = sector;
        block_count = count;
        start_read  = 1'b1;
        @(posedge clk);
        #1;
        start_read  = 1'b0;
    endtask

    task automatic wait_idle();
        while (busy) @(negedge clk);       // Watchdog bounds this loop
    endtask

    task automatic verify_read(input string name, input sd_pkg::sector_t base,
                               input int good_blocks, input int cmds, input int log_start);
        check({name, " byte count"}, 32'(good_blocks * sd_pkg::BLOCK_BYTES),
              32'(rx_q.size()));
        for (int b = 0; b < good_blocks; b++) begin
            for (int i = 0; i < sd_pkg::BLOCK_BYTES; i++) begin
                check({name, " data"}, 32'(expected_byte(base + 32'(b), i)),
                      32'(rx_q[b * sd_pkg::BLOCK_BYTES + i]));
            end
        end
        check({name, " CMD17 count"}, 32'(cmds), 32'(u_card.cmd17_count - log_start));
        for (int k = 0; k < cmds; k++) begin
            check({name, " CMD17 arg"}, base + 32'(k), u_card.cmd17_args[log_start + k]);
        end
    endtask

    initial begin
        int              multi_count;
        int              bad_count;
        int              bad_offset;
        int              log_start;
        int              rx_before;
        int              total_blocks;
        sd_pkg::sector_t single_sector;
        sd_pkg::sector_t multi_sector;
        sd_pkg::sector_t busy_sector;
        sd_pkg::sector_t bad_base;

        rst_n       = 1'b0;
        start_read  = 1'b0;
        sector_addr = '0;
        block_count = '0;
        bad_en      = 1'b0;
        bad_sector  = '0;
        void'($urandom(10589));
        single_sector = $urandom;
        multi_sector  = $urandom;
        busy_sector   = $urandom;
        bad_base      = $urandom;
        multi_count   = $urandom_range(4, 1);
        bad_count     = $urandom_range(4, 2);
        bad_offset    = $urandom_range(bad_count - 1, 1);   // At least one good block first
        total_blocks  = 1 + multi_count + 1 + bad_count + 2;
        watchdog_ns   = 2 * (INIT_BYTES * SLOW_BYTE_NS + total_blocks * 600 * FAST_BYTE_NS);

        // Init sequence
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        check("init busy", 32'd1, 32'(busy));
        wait_idle();
        check("init error", 32'd0, 32'(error));
        check("init ACMD41 retries", 32'd3, 32'(u_card.acmd41_retries));
        check("init CMD16 arg", 32'd512, u_card.blocklen_arg);

        // Single block
        rx_q.delete();
        log_start = u_card.cmd17_count;
        strobe_read(single_sector, 8'd1);
        check("single busy", 32'd1, 32'(busy));
        wait_idle();
        verify_read("single", single_sector, 1, 1, log_start);
        check("single error", 32'd0, 32'(error));

        // Several consecutive blocks
        rx_q.delete();
        log_start = u_card.cmd17_count;
        strobe_read(multi_sector, 8'(multi_count));
        wait_idle();
        verify_read("multi", multi_sector, multi_count, multi_count, log_start);
        check("multi error", 32'd0, 32'(error));

        // Zero block count is ignored
        rx_q.delete();
        log_start = u_card.cmd17_count;
        strobe_read(busy_sector, 8'd0);
        check("zero count busy", 32'd0, 32'(busy));
        repeat (50) @(negedge clk);
        verify_read("zero count", busy_sector, 0, 0, log_start);

        // Strobe while busy is ignored
        strobe_read(busy_sector, 8'd1);
        repeat (20) @(posedge clk);
        check("busy strobe busy", 32'd1, 32'(busy));
        strobe_read(busy_sector + 32'd100, 8'd2);
        wait_idle();
        verify_read("busy strobe", busy_sector, 1, 1, log_start);

        // Missing token on one sector
        @(posedge clk);
        #1;
        bad_sector = bad_base + 32'(bad_offset);
        bad_en     = 1'b1;
        rx_q.delete();
        log_start = u_card.cmd17_count;
        strobe_read(bad_base, 8'(bad_count));
        wait_idle();
        verify_read("bad sector", bad_base, bad_offset, bad_offset + 1, log_start);
        check("bad sector error", 32'd1, 32'(error));
        rx_before = rx_q.size();
        log_start = u_card.cmd17_count;
        strobe_read(single_sector, 8'd1);
        repeat (50) @(negedge clk);
        check("after error busy", 32'd0, 32'(busy));
        check("after error error", 32'd1, 32'(error));
        check("after error bytes", 32'(rx_before), 32'(rx_q.size()));
        check("after error CMD17", 32'(log_start), 32'(u_card.cmd17_count));

        if (u_dut.u_assert.fail_count != 0) begin
            $display("Protocol assertions failed %0d times", u_dut.u_assert.fail_count);
            $display("Test failures found");
            $fatal(1, "assertion failures");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
source/sd_pkg.sv
source/sd_spi_engine.sv
source/sd_transaction.sv
source/sd_sequencer.sv
source/sd_reader_top.sv
tb/tb_sd_card.sv
tb/tb_sd_reader_assert.sv
tb/tb_sd_reader.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_sd_reader
FILELIST = filelist.f

OBJ_DIR  = obj_dir
SIM      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	elif ! grep -q "All tests passed!" $(LOG); then \
		echo "Simulation stopped early"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
